// File: sim.f
+incdir+design
design/exec_pkg.sv
design/operand_if.sv
design/operand_select.sv
design/seq_multiplier.sv
design/alu_core.sv
design/exec_unit.sv
bench/tb_exec_unit.sv

// File: Makefile
TOP = tb_exec_unit
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module exec_unit

clean:
	rm -rf obj_dir $(LOG)

// File: bench/tb_exec_unit.sv
`timescale 1ns/1ps
`include "exec_settings.svh"

module tb_exec_unit;
    import exec_pkg::*;

    localparam int XLEN = `EXEC_XLEN;
    localparam logic [63:0] LFSR_TAPS = 64'hD800_0000_0000_0000;
    localparam logic [63:0] MIN_NEG = 64'h8000_0000_0000_0000;
    localparam int N_MUL = 6;
    // reset, single-cycle, word, division edges, multiply, flush
    localparam int TEST_COUNT = 1 + 19 * 6 + 13 + 6 + N_MUL + 1;
    localparam int WATCHDOG_CYCLES = TEST_COUNT * (`EXEC_MUL_STEPS + 10);

    logic            clk;
    logic            arst_n;
    logic            flush;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic [XLEN-1:0] csr;
    logic [XLEN-1:0] imm;
    sel_a_e          sel_a;
    sel_b_e          sel_b;
    alu_op_e         op;
    logic            word;
    logic [XLEN-1:0] res;
    logic            alu_wait;

    // values the next operation will drive
    logic [XLEN-1:0] v_pc;
    logic [XLEN-1:0] v_rs1;
    logic [XLEN-1:0] v_rs2;
    logic [XLEN-1:0] v_csr;
    logic [XLEN-1:0] v_imm;
    logic [63:0]     lfsr_state;

    exec_unit u_exec_unit (
        .clk      (clk),
        .arst_n   (arst_n),
        .flush    (flush),
        .pc       (pc),
        .rs1      (rs1),
        .rs2      (rs2),
        .csr      (csr),
        .imm      (imm),
        .sel_a    (sel_a),
        .sel_b    (sel_b),
        .op       (op),
        .word     (word),
        .res      (res),
        .alu_wait (alu_wait)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [63:0] lfsr_step(logic [63:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [63:0] r);
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[62:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic fill_random_inputs();
        take_bits(64, v_pc);
        take_bits(64, v_rs1);
        take_bits(64, v_rs2);
        take_bits(64, v_csr);
        take_bits(64, v_imm);
    endtask

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("error: time %0t signal %s got %h expected %h", $time, name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [63:0] operand_a(sel_a_e sa, logic w);
        if (sa == sel_a_pc) begin
            return v_pc;
        end
        if (w) begin
            return {32'b0, v_rs1[31:0]};
        end
        return v_rs1;
    endfunction

    function automatic logic [63:0] operand_b(sel_b_e sb);
        if (sb == sel_b_rs2) begin
            return v_rs2;
        end
        if (sb == sel_b_csr) begin
            return v_csr;
        end
        return v_imm;
    endfunction

    // expected result straight from the opcode rules
    function automatic logic [63:0] ref_result(alu_op_e o, logic [63:0] a, logic [63:0] b,
                                               logic w);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [31:0] lo;
        logic [5:0]         sh;
        logic [63:0]        r;
        sa = a;
        sb = b;
        lo = a[31:0];
        sh = b[5:0];
        r  = '0;
        case (o)
            op_add:    r = a + b;
            op_sub:    r = a - b;
            op_pass_a: r = a;
            op_pass_b: r = b;
            op_xor:    r = a ^ b;
            op_or:     r = a | b;
            op_and:    r = a & b;
            op_sll:    r = a << sh;
            op_srl:    r = a >> sh;
            op_sra: begin
                if (w) begin
                    r = {32'b0, lo >>> sh};
                end else begin
                    r = sa >>> sh;
                end
            end
            op_slt:    r = (sa < sb) ? 64'd1 : 64'd0;
            op_sltu:   r = (a < b) ? 64'd1 : 64'd0;
            op_eq:     r = (a == b) ? 64'd1 : 64'd0;
            op_ge:     r = (sa >= sb) ? 64'd1 : 64'd0;
            op_geu:    r = (a >= b) ? 64'd1 : 64'd0;
            op_mul:    r = a * b;
            op_div: begin
                if (b == '0) r = '1;
                else if (a == MIN_NEG && b == '1) r = a;
                else r = sa / sb;
            end
            op_divu:   r = (b == '0) ? '1 : a / b;
            op_rem: begin
                if (b == '0) r = a;
                else if (a == MIN_NEG && b == '1) r = '0;
                else r = sa % sb;
            end
            op_remu:   r = (b == '0) ? a : a % b;
            default:   r = '0;
        endcase
        return r;
    endfunction

    task automatic drive_inputs(input alu_op_e o, input sel_a_e sa, input sel_b_e sb,
                                input logic w);
        @(posedge clk);
        pc    <= v_pc;
        rs1   <= v_rs1;
        rs2   <= v_rs2;
        csr   <= v_csr;
        imm   <= v_imm;
        sel_a <= sa;
        sel_b <= sb;
        op    <= o;
        word  <= w;
    endtask

    task automatic apply_single(input alu_op_e o, input sel_a_e sa, input sel_b_e sb,
                                input logic w);
        logic [63:0] exp;
        exp = ref_result(o, operand_a(sa, w), operand_b(sb), w);
        drive_inputs(o, sa, sb, w);
        @(posedge clk);
        @(negedge clk);
        check_value("res", res, exp);
        check_value("alu_wait", 64'(alu_wait), 64'd0);
    endtask

    task automatic test_reset();
        @(negedge clk);
        check_value("res", res, 64'd0);
        check_value("alu_wait", 64'(alu_wait), 64'd0);
    endtask

    task automatic test_single_cycle();
        alu_op_e o;
        for (int k = 0; k < 20; k++) begin
            o = alu_op_e'(k);
            if (o != op_mul) begin
                for (int s = 0; s < 6; s++) begin
                    fill_random_inputs();
                    apply_single(o, sel_a_e'(s / 3), sel_b_e'(s % 3), 1'b0);
                end
            end
        end
    endtask

    task automatic test_word();
        for (int i = 0; i < 4; i++) begin
            fill_random_inputs();
            apply_single(op_pass_a, sel_a_rs1, sel_b_imm, 1'b1);
            apply_single(op_add, sel_a_rs1, sel_b_rs2, 1'b1);
            apply_single(op_sra, sel_a_rs1, sel_b_imm, 1'b1);
        end
        // negative low word with a set upper half that must not leak in
        v_rs1 = 64'hFFFF_FFFF_8000_0000;
        v_imm = 64'd4;
        apply_single(op_sra, sel_a_rs1, sel_b_imm, 1'b1);
        check_value("res", res, 64'h0000_0000_F800_0000);
    endtask

    task automatic test_div_edges();
        fill_random_inputs();
        v_rs2 = '0;
        apply_single(op_div, sel_a_rs1, sel_b_rs2, 1'b0);
        apply_single(op_divu, sel_a_rs1, sel_b_rs2, 1'b0);
        apply_single(op_rem, sel_a_rs1, sel_b_rs2, 1'b0);
        apply_single(op_remu, sel_a_rs1, sel_b_rs2, 1'b0);
        v_rs1 = MIN_NEG;
        v_rs2 = '1;
        apply_single(op_div, sel_a_rs1, sel_b_rs2, 1'b0);
        apply_single(op_rem, sel_a_rs1, sel_b_rs2, 1'b0);
    endtask

    task automatic test_multiply();
        logic [63:0] exp;
        fill_random_inputs();
        exp = ref_result(op_mul, operand_a(sel_a_rs1, 1'b0), operand_b(sel_b_rs2), 1'b0);
        drive_inputs(op_mul, sel_a_rs1, sel_b_rs2, 1'b0);
        @(posedge clk);
        @(negedge clk);
        check_value("alu_wait", 64'(alu_wait), 64'd1);
        @(negedge alu_wait);
        // leave mul on the edge that ends the stall, or a second multiply starts
        op <= op_pass_a;
        @(negedge clk);
        check_value("res", res, exp);
    endtask

    task automatic test_flush();
        logic [63:0] old_res;
        fill_random_inputs();
        drive_inputs(op_mul, sel_a_rs1, sel_b_rs2, 1'b0);
        repeat (10) @(posedge clk);
        @(negedge clk);
        check_value("alu_wait", 64'(alu_wait), 64'd1);
        old_res = res;
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        op    <= op_add;
        @(negedge clk);
        check_value("alu_wait", 64'(alu_wait), 64'd0);
        check_value("res", res, old_res);
        @(posedge clk);
        @(negedge clk);
        check_value("res", res, v_rs1 + v_rs2);
        check_value("alu_wait", 64'(alu_wait), 64'd0);
    endtask

    initial begin
        lfsr_state = 64'd48;
        arst_n     = 1'b0;
        flush      = 1'b0;
        pc         = '0;
        rs1        = '0;
        rs2        = '0;
        csr        = '0;
        imm        = '0;
        sel_a      = sel_a_pc;
        sel_b      = sel_b_imm;
        op         = op_add;
        word       = 1'b0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        test_reset();
        test_single_cycle();
        test_word();
        test_div_edges();
        for (int i = 0; i < N_MUL; i++) begin
            test_multiply();
        end
        test_flush();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: design/exec_unit.sv
`timescale 1ns/1ps
`include "exec_settings.svh"

module exec_unit (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  flush,
    input  logic [`EXEC_XLEN-1:0] pc,
    input  logic [`EXEC_XLEN-1:0] rs1,
    input  logic [`EXEC_XLEN-1:0] rs2,
    input  logic [`EXEC_XLEN-1:0] csr,
    input  logic [`EXEC_XLEN-1:0] imm,
    input  exec_pkg::sel_a_e      sel_a,
    input  exec_pkg::sel_b_e      sel_b,
    input  exec_pkg::alu_op_e     op,
    input  logic                  word,
    output logic [`EXEC_XLEN-1:0] res,
    output logic                  alu_wait
);

    // operands from selector to core
    operand_if u_ops ();

    operand_select u_operand_select (
        .pc    (pc),
        .rs1   (rs1),
        .rs2   (rs2),
        .csr   (csr),
        .imm   (imm),
        .sel_a (sel_a),
        .sel_b (sel_b),
        .op    (op),
        .word  (word),
        .ops   (u_ops.source)
    );

    alu_core u_alu_core (
        .clk      (clk),
        .arst_n   (arst_n),
        .flush    (flush),
        .ops      (u_ops.sink),
        .res      (res),
        .alu_wait (alu_wait)
    );

endmodule

// File: design/alu_core.sv
`timescale 1ns/1ps
`include "exec_settings.svh"

module alu_core (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  flush,
    operand_if.sink               ops,
    output logic [`EXEC_XLEN-1:0] res,
    output logic                  alu_wait
);
    import exec_pkg::*;

    localparam int XLEN     = `EXEC_XLEN;
    localparam int WAIT_MAX = `EXEC_MUL_STEPS + 2;

    logic                          mul_start;
    logic                          mul_done;
    logic [XLEN-1:0]               mul_product;
    logic [`EXEC_SHAMT_W-1:0]      shamt;
    logic signed [XLEN-1:0]        sa;
    logic signed [XLEN-1:0]        sb;
    logic signed [31:0]            sa_lo;
    logic signed [XLEN-1:0]        sdiv;
    logic signed [XLEN-1:0]        srem;
    logic                          div_zero;
    logic                          div_ovf;
    logic [XLEN-1:0]               quot_s;
    logic [XLEN-1:0]               rem_s;
    logic [XLEN-1:0]               quot_u;
    logic [XLEN-1:0]               rem_u;
    logic [$clog2(WAIT_MAX+1)-1:0] wait_cnt;

    assign shamt = ops.b[`EXEC_SHAMT_W-1:0];
    assign sa    = ops.a;
    assign sb    = ops.b;
    assign sa_lo = ops.a[31:0];
    assign sdiv  = sa / sb;
    assign srem  = sa % sb;

    // RISC-V rules for zero divisor and most negative / -1
    assign div_zero = (ops.b == '0);
    assign div_ovf  = (ops.a == {1'b1, {(XLEN-1){1'b0}}}) && (ops.b == '1);
    assign quot_s   = div_zero ? '1 : (div_ovf ? ops.a : sdiv);
    assign rem_s    = div_zero ? ops.a : (div_ovf ? '0 : srem);
    assign quot_u   = div_zero ? '1 : ops.a / ops.b;
    assign rem_u    = div_zero ? ops.a : ops.a % ops.b;

    seq_multiplier u_seq_multiplier (
        .clk     (clk),
        .arst_n  (arst_n),
        .flush   (flush),
        .start   (mul_start),
        .a       (ops.a),
        .b       (ops.b),
        .done    (mul_done),
        .product (mul_product)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res       <= '0;
            alu_wait  <= 1'b0;
            mul_start <= 1'b0;
        end else if (flush) begin
            // abort the multiply and keep res
            alu_wait  <= 1'b0;
            mul_start <= 1'b0;
        end else begin
            mul_start <= 1'b0;
            if (ops.op != op_mul) begin
                alu_wait <= 1'b0;
            end
            case (ops.op)
                op_add:    res <= ops.a + ops.b;
                op_sub:    res <= ops.a - ops.b;
                op_pass_a: res <= ops.a;
                op_pass_b: res <= ops.b;
                op_xor:    res <= ops.a ^ ops.b;
                op_or:     res <= ops.a | ops.b;
                op_and:    res <= ops.a & ops.b;
                op_sll:    res <= ops.a << shamt;
                op_srl:    res <= ops.a >> shamt;
                op_sra: begin
                    if (ops.word) begin
                        res <= {{(XLEN-32){1'b0}}, sa_lo >>> shamt};
                    end else begin
                        res <= sa >>> shamt;
                    end
                end
                op_slt:    res <= XLEN'(sa < sb);
                op_sltu:   res <= XLEN'(ops.a < ops.b);
                op_eq:     res <= XLEN'(ops.a == ops.b);
                op_ge:     res <= XLEN'(sa >= sb);
                op_geu:    res <= XLEN'(ops.a >= ops.b);
                op_mul: begin
                    // stall and kick the multiplier once before waiting for done
                    if (!alu_wait) begin
                        alu_wait  <= 1'b1;
                        mul_start <= 1'b1;
                    end else if (mul_done) begin
                        alu_wait <= 1'b0;
                        res      <= mul_product;
                    end
                end
                op_div:    res <= quot_s;
                op_divu:   res <= quot_u;
                op_rem:    res <= rem_s;
                op_remu:   res <= rem_u;
                default:   res <= '0;
            endcase
        end
    end

    // length of the current stall
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wait_cnt <= '0;
        end else if (alu_wait) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0;
        end
    end

    // upstream must hold the opcode during a stall
    a_op_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        (alu_wait && !flush) |-> $stable(ops.op)
    ) else $error("op changed while alu_wait high");

    a_done_in_wait: assert property (
        @(posedge clk) disable iff (!arst_n)
        mul_done |-> alu_wait
    ) else $error("multiplier done outside a stall");

    a_wait_bounded: assert property (
        @(posedge clk) disable iff (!arst_n)
        alu_wait |-> (wait_cnt < WAIT_MAX)
    ) else $error("alu_wait held too long");

endmodule

// File: design/seq_multiplier.sv
`timescale 1ns/1ps
`include "exec_settings.svh"

module seq_multiplier (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  flush,
    input  logic                  start,
    input  logic [`EXEC_XLEN-1:0] a,
    input  logic [`EXEC_XLEN-1:0] b,
    output logic                  done,
    output logic [`EXEC_XLEN-1:0] product
);
    import exec_pkg::*;

    localparam int CNT_W = $clog2(`EXEC_MUL_STEPS);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`EXEC_MUL_STEPS - 1);

    mul_state_e            state;
    logic [CNT_W-1:0]      step_cnt;
    logic [`EXEC_XLEN-1:0] mcand;
    logic [`EXEC_XLEN-1:0] mplier;
    logic [`EXEC_XLEN-1:0] acc;

    // control path where flush overrides start and stepping
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= ms_idle;
            step_cnt <= '0;
        end else if (flush) begin
            state    <= ms_idle;
            step_cnt <= '0;
        end else begin
            case (state)
                ms_idle: begin
                    if (start) begin
                        state    <= ms_run;
                        step_cnt <= '0;
                    end
                end
                ms_run: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (step_cnt == LAST_STEP) begin
                        state <= ms_done;
                    end
                end
                default: state <= ms_idle;
            endcase
        end
    end

    // shift-and-add datapath handling one multiplier bit per step
    always_ff @(posedge clk) begin
        if (state == ms_idle && start) begin
            mcand  <= a;
            mplier <= b;
            acc    <= '0;
        end else if (state == ms_run) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // done lasts exactly one cycle since ms_done always returns to idle
    assign done    = (state == ms_done);
    assign product = acc;

    // the core must not restart a multiply that is still in flight
    a_start_when_idle: assert property (
        @(posedge clk) disable iff (!arst_n)
        start |-> (state == ms_idle)
    ) else $error("multiplier started while busy");

endmodule

// File: design/operand_select.sv
`timescale 1ns/1ps
`include "exec_settings.svh"

module operand_select (
    input  logic [`EXEC_XLEN-1:0] pc,
    input  logic [`EXEC_XLEN-1:0] rs1,
    input  logic [`EXEC_XLEN-1:0] rs2,
    input  logic [`EXEC_XLEN-1:0] csr,
    input  logic [`EXEC_XLEN-1:0] imm,
    input  exec_pkg::sel_a_e      sel_a,
    input  exec_pkg::sel_b_e      sel_b,
    input  exec_pkg::alu_op_e     op,
    input  logic                  word,
    operand_if.source             ops
);
    import exec_pkg::*;

    logic [`EXEC_XLEN-1:0] rs1_sel;

    // word forms only look at the low half of rs1
    assign rs1_sel = word ? {{(`EXEC_XLEN-32){1'b0}}, rs1[31:0]} : rs1;

    always_comb begin
        case (sel_a)
            sel_a_rs1: ops.a = rs1_sel;
            default:   ops.a = pc;
        endcase
    end

    always_comb begin
        case (sel_b)
            sel_b_rs2: ops.b = rs2;
            sel_b_csr: ops.b = csr;
            default:   ops.b = imm;
        endcase
    end

    // core still needs these for sra and mul control
    assign ops.op   = op;
    assign ops.word = word;

endmodule

// File: design/operand_if.sv
`timescale 1ns/1ps
`include "exec_settings.svh"

interface operand_if;
    import exec_pkg::*;

    // selected operands
    logic [`EXEC_XLEN-1:0] a;
    logic [`EXEC_XLEN-1:0] b;
    // operation and 32-bit word flag
    alu_op_e               op;
    logic                  word;

    modport source (
        output a,
        output b,
        output op,
        output word
    );

    modport sink (
        input a,
        input b,
        input op,
        input word
    );

endinterface

// File: design/exec_pkg.sv
package exec_pkg;

    // execute stage opcodes
    typedef enum logic [4:0] {
        op_add,
        op_sub,
        op_pass_a,
        op_pass_b,
        op_xor,
        op_or,
        op_and,
        op_sll,
        op_srl,
        op_sra,
        op_slt,
        op_sltu,
        op_eq,
        op_ge,
        op_geu,
        op_mul,
        op_div,
        op_divu,
        op_rem,
        op_remu
    } alu_op_e;

    // first operand source
    typedef enum logic [1:0] {
        sel_a_pc  = 2'd0,
        sel_a_rs1 = 2'd1
    } sel_a_e;

    // second operand source
    // the unused code decodes as imm
    typedef enum logic [1:0] {
        sel_b_imm = 2'd0,
        sel_b_rs2 = 2'd1,
        sel_b_csr = 2'd2
    } sel_b_e;

    // iterative multiplier states
    typedef enum logic [1:0] {
        ms_idle,
        ms_run,
        ms_done
    } mul_state_e;

endpackage

// File: design/exec_settings.svh
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// datapath width of the execute stage
`define EXEC_XLEN 64

// shift amount taken from the low bits of operand b
`define EXEC_SHAMT_W 6

// one multiplier bit per step, so equal to the data width
`define EXEC_MUL_STEPS 64

`endif
